//--- flitSwitch.f
logic/flitSwitchPkg.sv
logic/inputBuffer.sv
logic/holdTimer.sv
logic/portArbiter.sv
logic/outputStage.sv
logic/flitSwitch.sv
verification/flitSwitchTb.sv

//--- Makefile
TOP = flitSwitchTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flitSwitch.f --top-module flitSwitch

sim:
	verilator --binary --timing --assert -f flitSwitch.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/flitSwitchTb.sv
`timescale 1ns/100ps

module flitSwitchTb;

  logic clk;
  logic rst;
  flitSwitchPkg::flit_t inFlit [flitSwitchPkg::NumPorts];
  flitSwitchPkg::portMask_t inValid;
  flitSwitchPkg::portMask_t creditReturn;
  flitSwitchPkg::flit_t outFlit;
  logic outValid;
  logic creditIn;

  // Flits waiting at each sender and flits sent but not yet seen on the output
  flitSwitchPkg::flit_t txQ [flitSwitchPkg::NumPorts][$];
  flitSwitchPkg::flit_t expQ [flitSwitchPkg::NumPorts][$];
  int upCredits [flitSwitchPkg::NumPorts];
  int seqNum [flitSwitchPkg::NumPorts];
  int dsCredits;
  int pending;
  int remaining;
  int curSrc;
  int lastSrc;
  logic [31:0] rngState;
  logic noGaps;
  logic fairMode;

  logic integChk;
  logic flitChk;
  logic fairChk;
  logic strayChk;
  logic [5:0] integExp;
  logic [5:0] integAct;
  flitSwitchPkg::flit_t flitExp;
  flitSwitchPkg::flit_t flitAct;
  int fairExp;
  int fairAct;

  flitSwitch uut
  (
    .clk,
    .rst,
    .inFlit,
    .inValid,
    .creditReturn,
    .outFlit,
    .outValid,
    .creditIn
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic flagMismatch(input string testName, input logic [31:0] expVal,
                              input logic [31:0] actVal);
    $display("ERROR %s: expected %0h, actual %0h", testName, expVal, actVal);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // The head carries the source port in dest, later flits carry it in the payload
  task automatic queuePacket(input int port, input int len);
    flitSwitchPkg::flit_t f;
    f.kind = flitSwitchPkg::Head;
    f.data.header.dest = 4'(port);
    f.data.header.length = flitSwitchPkg::LengthWidth'(len);
    txQ[port].push_back(f);
    for (int k = 1; k < len; k++)
    begin
      f.kind = (k == len - 1) ? flitSwitchPkg::Tail : flitSwitchPkg::Body;
      f.data.payload = {4'(port), 12'(seqNum[port])};
      seqNum[port]++;
      txQ[port].push_back(f);
    end
  endtask

  function automatic logic allDrained();
    logic done;
    done = (remaining == 0) && (pending == 0);
    for (int i = 0; i < flitSwitchPkg::NumPorts; i++)
    begin
      if (txQ[i].size() != 0 || expQ[i].size() != 0 ||
          upCredits[i] != flitSwitchPkg::BufDepth)
        done = 1'b0;
    end
    return done;
  endfunction

  task automatic waitDrain(input int limit);
    int cycles;
    cycles = 0;
    while (!allDrained())
    begin
      if (cycles >= limit)
        abortRun("Timed out before every packet arrived and every credit came back");
      else
      begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin : trafficModel
    flitSwitchPkg::flit_t sendFlit;
    flitSwitchPkg::flitKind_t expKind;
    logic [3:0] tag;
    logic [3:0] expTag;
    int srcIdx;
    integChk <= 1'b0;
    flitChk <= 1'b0;
    fairChk <= 1'b0;
    strayChk <= 1'b0;
    if (rst)
    begin
      inValid <= '0;
      creditIn <= 1'b0;
      for (int i = 0; i < flitSwitchPkg::NumPorts; i++)
      begin
        upCredits[i] = flitSwitchPkg::BufDepth;
        txQ[i].delete();
        expQ[i].delete();
      end
      dsCredits = flitSwitchPkg::OutCredits;
      pending = 0;
      remaining = 0;
      lastSrc = int'(flitSwitchPkg::PortS);
    end
    else
    begin
      // Senders spend one credit per flit and regain one per returned pulse
      for (int i = 0; i < flitSwitchPkg::NumPorts; i++)
      begin
        if (creditReturn[i])
          upCredits[i] = upCredits[i] + 1;
        rngState = xorshift(rngState);
        if (txQ[i].size() > 0 && upCredits[i] > 0 && (noGaps || rngState[1:0] != 2'b00))
        begin
          sendFlit = txQ[i].pop_front();
          expQ[i].push_back(sendFlit);
          inFlit[i] <= sendFlit;
          inValid[i] <= 1'b1;
          upCredits[i] = upCredits[i] - 1;
        end
        else
          inValid[i] <= 1'b0;
      end

      if (outValid)
      begin
        dsCredits = dsCredits - 1;
        pending = pending + 1;
        if (outFlit.kind == flitSwitchPkg::Head)
          tag = outFlit.data.header.dest;
        else
          tag = outFlit.data.payload[15:12];
        expKind = (remaining == 0) ? flitSwitchPkg::Head :
                  (remaining == 1) ? flitSwitchPkg::Tail : flitSwitchPkg::Body;
        expTag = (remaining == 0) ? tag : 4'(curSrc);
        integChk <= 1'b1;
        integExp <= {expKind, expTag};
        integAct <= {outFlit.kind, tag};
        if (outFlit.kind == flitSwitchPkg::Head)
        begin
          if (fairMode)
          begin
            fairChk <= 1'b1;
            fairExp <= (lastSrc + 1) % flitSwitchPkg::NumPorts;
            fairAct <= int'(tag);
          end
          lastSrc = int'(tag);
          curSrc = int'(tag);
          remaining = int'(outFlit.data.header.length) - 1;
        end
        else if (remaining > 0)
          remaining = remaining - 1;
        srcIdx = int'(tag);
        if (srcIdx < flitSwitchPkg::NumPorts && expQ[srcIdx].size() > 0)
        begin
          flitChk <= 1'b1;
          flitExp <= expQ[srcIdx].pop_front();
          flitAct <= outFlit;
        end
        else
          strayChk <= 1'b1;
      end

      // Downstream frees its slots after a random delay
      rngState = xorshift(rngState);
      if (pending > 0 && rngState[2:0] < 3'd3)
      begin
        creditIn <= 1'b1;
        dsCredits = dsCredits + 1;
        pending = pending - 1;
      end
      else
        creditIn <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (rst) integChk |-> integAct == integExp)
    else flagMismatch("packet integrity", 32'($sampled(integExp)), 32'($sampled(integAct)));

  assert property (@(posedge clk) disable iff (rst) flitChk |-> flitAct == flitExp)
    else flagMismatch("payload order", 32'($sampled(flitExp)), 32'($sampled(flitAct)));

  assert property (@(posedge clk) disable iff (rst) fairChk |-> fairAct == fairExp)
    else flagMismatch("rotating fairness", 32'($sampled(fairExp)), 32'($sampled(fairAct)));

  assert property (@(posedge clk) disable iff (rst) !strayChk)
    else abortRun("A flit reached the output with no outstanding flit from its port");

  assert property (@(posedge clk) disable iff (rst) outValid |-> dsCredits != 0)
    else abortRun("The output sent a flit while the receiver had no free slot");

  assert property (@(posedge clk) rst |=> (!outValid && creditReturn == '0))
    else abortRun("outValid or creditReturn was high right after reset");

  for (genvar i = 0; i < flitSwitchPkg::NumPorts; i++)
  begin : genCreditCheck
    assert property (@(posedge clk) disable iff (rst) upCredits[i] <= flitSwitchPkg::BufDepth)
      else abortRun($sformatf("Port %0d got back more credits than flits it sent", i));
  end

  initial
  begin
    int port;
    int len;
    rst = 1'b1;
    inValid = '0;
    creditIn = 1'b0;
    for (int i = 0; i < flitSwitchPkg::NumPorts; i++)
    begin
      inFlit[i] = '0;
      seqNum[i] = 0;
    end
    rngState = 32'h399c_f87b;
    noGaps = 1'b0;
    fairMode = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (int n = 0; n < 40; n++)
    begin
      @(negedge clk);
      rngState = xorshift(rngState);
      port = int'(rngState[7:0]) % flitSwitchPkg::NumPorts;
      len = 2 + int'(rngState[15:8]) % 5;
      queuePacket(port, len);
      repeat (int'(rngState[17:16])) @(negedge clk);
    end
    waitDrain(5000);

    // Every port offers a packet in the same cycle while the link is idle
    for (int round = 0; round < 2; round++)
    begin
      fairMode = 1'b1;
      noGaps = 1'b1;
      for (int i = 0; i < flitSwitchPkg::NumPorts; i++)
      begin
        rngState = xorshift(rngState);
        queuePacket(i, 2 + int'(rngState[7:0]) % 5);
      end
      waitDrain(1000);
      fairMode = 1'b0;
      noGaps = 1'b0;
    end

    for (int n = 0; n < 10; n++)
      queuePacket(n % flitSwitchPkg::NumPorts, 6);
    repeat (12) @(negedge clk);
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    queuePacket(int'(flitSwitchPkg::PortE), 5);
    waitDrain(1000);

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- logic/flitSwitch.sv
`timescale 1ns/100ps

module flitSwitch
(
  input  logic                     clk,
  input  logic                     rst,
  input  flitSwitchPkg::flit_t     inFlit [flitSwitchPkg::NumPorts],
  input  flitSwitchPkg::portMask_t inValid,
  output flitSwitchPkg::portMask_t creditReturn,
  output flitSwitchPkg::flit_t     outFlit,
  output logic                     outValid,
  input  logic                     creditIn
);

  flitSwitchPkg::portMask_t req;
  flitSwitchPkg::portMask_t pop;
  flitSwitchPkg::flit_t frontFlit [flitSwitchPkg::NumPorts];
  logic [flitSwitchPkg::LengthWidth-1:0] frontLength [flitSwitchPkg::NumPorts];
  logic [flitSwitchPkg::SelWidth-1:0] sel;
  logic canSend;
  logic fwd;

  for (genvar i = 0; i < flitSwitchPkg::NumPorts; i++)
  begin : genBuf
    inputBuffer buffer
    (
      .clk,
      .rst,
      .inFlit(inFlit[i]),
      .inValid(inValid[i]),
      .pop(pop[i]),
      .req(req[i]),
      .frontFlit(frontFlit[i]),
      .frontLength(frontLength[i]),
      .creditReturn(creditReturn[i])
    );
  end

  portArbiter arbiter
  (
    .clk,
    .rst,
    .req,
    .frontFlit,
    .frontLength,
    .canSend,
    .pop,
    .sel
  );

  // At most one port pops in a cycle
  assign fwd = |pop;

  outputStage outStage
  (
    .clk,
    .rst,
    .frontFlit,
    .sel,
    .fwd,
    .creditIn,
    .canSend,
    .outFlit,
    .outValid
  );

endmodule

//--- logic/outputStage.sv
`timescale 1ns/100ps

module outputStage
(
  input  logic                               clk,
  input  logic                               rst,
  input  flitSwitchPkg::flit_t               frontFlit [flitSwitchPkg::NumPorts],
  input  logic [flitSwitchPkg::SelWidth-1:0] sel,
  input  logic                               fwd,
  input  logic                               creditIn,
  output logic                               canSend,
  output flitSwitchPkg::flit_t               outFlit,
  output logic                               outValid
);

  logic [flitSwitchPkg::CreditWidth-1:0] credits;

  always_ff @(posedge clk)
  begin
    if (fwd)
    begin
      outFlit <= frontFlit[sel];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      credits <= flitSwitchPkg::CreditWidth'(flitSwitchPkg::OutCredits);
    end
    else
    begin
      outValid <= fwd;
      // A forward and a returned credit in one cycle cancel out
      case ({fwd, creditIn})
        2'b10: credits <= credits - flitSwitchPkg::CreditWidth'(1);
        2'b01: credits <= credits + flitSwitchPkg::CreditWidth'(1);
        default: credits <= credits;
      endcase
    end
  end

  assign canSend = (credits != '0);

  // The receiver never returns more credits than its buffer holds
  assert property (@(posedge clk) disable iff (rst)
    credits <= flitSwitchPkg::CreditWidth'(flitSwitchPkg::OutCredits));

  // The arbiter forwards only while a downstream slot is free
  assert property (@(posedge clk) disable iff (rst)
    fwd |-> canSend);

endmodule

//--- logic/portArbiter.sv
`timescale 1ns/100ps

module portArbiter
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  flitSwitchPkg::portMask_t             req,
  input  flitSwitchPkg::flit_t                 frontFlit [flitSwitchPkg::NumPorts],
  input  logic [flitSwitchPkg::LengthWidth-1:0] frontLength [flitSwitchPkg::NumPorts],
  input  logic                                 canSend,
  output flitSwitchPkg::portMask_t             pop,
  output logic [flitSwitchPkg::SelWidth-1:0]   sel
);

  flitSwitchPkg::arbState_t state;
  flitSwitchPkg::arbState_t stateNext;
  flitSwitchPkg::portMask_t grant;
  flitSwitchPkg::portMask_t pick;
  flitSwitchPkg::portMask_t headMask;
  flitSwitchPkg::portMask_t start;
  flitSwitchPkg::portMask_t advance;
  flitSwitchPkg::portMask_t timesUp;
  logic [flitSwitchPkg::SelWidth-1:0] rrFirst;
  logic [flitSwitchPkg::SelWidth-1:0] searchFrom;
  logic holdDone;
  logic grantFresh;

  function automatic logic [flitSwitchPkg::SelWidth-1:0] nextPort(
    input logic [flitSwitchPkg::SelWidth-1:0] p
  );
    case (p)
      flitSwitchPkg::PortL: nextPort = flitSwitchPkg::PortN;
      flitSwitchPkg::PortN: nextPort = flitSwitchPkg::PortE;
      flitSwitchPkg::PortE: nextPort = flitSwitchPkg::PortW;
      flitSwitchPkg::PortW: nextPort = flitSwitchPkg::PortS;
      flitSwitchPkg::PortS: nextPort = flitSwitchPkg::PortL;
      default: nextPort = flitSwitchPkg::PortL;
    endcase
  endfunction

  // First requester found walking the ring from the given port
  function automatic flitSwitchPkg::portMask_t rotatePick(
    input flitSwitchPkg::portMask_t reqs,
    input logic [flitSwitchPkg::SelWidth-1:0] first
  );
    flitSwitchPkg::portMask_t found;
    logic [flitSwitchPkg::SelWidth-1:0] idx;
    found = '0;
    idx = first;
    for (int k = 0; k < flitSwitchPkg::NumPorts; k++)
    begin
      if (found == '0 && reqs[idx])
        found[idx] = 1'b1;
      idx = nextPort(idx);
    end
    rotatePick = found;
  endfunction

  assign grant = state[flitSwitchPkg::NumPorts:1];
  assign holdDone = |(grant & timesUp);

  always_comb
  begin
    sel = '0;
    headMask = '0;
    for (int i = 0; i < flitSwitchPkg::NumPorts; i++)
    begin
      if (grant[i])
        sel = flitSwitchPkg::SelWidth'(i);
      headMask[i] = (frontFlit[i].kind == flitSwitchPkg::Head);
    end
  end

  // No forward in the release cycle, which leaves one gap between packets
  assign pop = grant & req & {flitSwitchPkg::NumPorts{canSend}} & ~timesUp;
  assign start = pop & headMask;
  assign advance = pop & ~headMask;

  assign searchFrom = state[0] ? rrFirst : nextPort(sel);

  always_comb
  begin
    pick = rotatePick(req, searchFrom);
    stateNext = state;
    if (state[0] || holdDone)
      stateNext = (pick == '0) ? flitSwitchPkg::StateIdle : {pick, 1'b0};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= flitSwitchPkg::StateIdle;
      rrFirst <= flitSwitchPkg::PortL;
      grantFresh <= 1'b0;
    end
    else
    begin
      state <= stateNext;
      if (!state[0])
        rrFirst <= nextPort(sel);
      if (state[0] || holdDone)
        grantFresh <= 1'b1;
      else if (|pop)
        grantFresh <= 1'b0;
    end
  end

  for (genvar i = 0; i < flitSwitchPkg::NumPorts; i++)
  begin : genTimer
    holdTimer timer
    (
      .clk,
      .rst,
      .start(start[i]),
      .advance(advance[i]),
      .length(frontLength[i]),
      .timesUp(timesUp[i])
    );

    // The forward that completes the length must be the tail
    assert property (@(posedge clk) disable iff (rst)
      pop[i] |=> (timesUp[i] == ($past(frontFlit[i].kind) == flitSwitchPkg::Tail)));
  end

  // The first forward of a grant is the head and no later one is
  assert property (@(posedge clk) disable iff (rst)
    |pop |-> ((frontFlit[sel].kind == flitSwitchPkg::Head) == grantFresh));

endmodule

//--- logic/holdTimer.sv
`timescale 1ns/100ps

module holdTimer
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 start,
  input  logic                                 advance,
  input  logic [flitSwitchPkg::LengthWidth-1:0] length,
  output logic                                 timesUp
);

  logic [flitSwitchPkg::LengthWidth-1:0] count;
  logic [flitSwitchPkg::LengthWidth-1:0] target;

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      target <= length;
    end
  end

  // The holder loses the grant exactly in the cycle timesUp is high
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (start)
      count <= flitSwitchPkg::LengthWidth'(1);
    else if (timesUp)
      count <= '0;
    else if (advance)
      count <= count + flitSwitchPkg::LengthWidth'(1);
  end

  assign timesUp = (count != '0) && (count == target);

endmodule

//--- logic/inputBuffer.sv
`timescale 1ns/100ps

module inputBuffer
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  flitSwitchPkg::flit_t                 inFlit,
  input  logic                                 inValid,
  input  logic                                 pop,
  output logic                                 req,
  output flitSwitchPkg::flit_t                 frontFlit,
  output logic [flitSwitchPkg::LengthWidth-1:0] frontLength,
  output logic                                 creditReturn
);

  flitSwitchPkg::flit_t mem [flitSwitchPkg::BufDepth];
  logic [flitSwitchPkg::PtrWidth-1:0] wrPtr;
  logic [flitSwitchPkg::PtrWidth-1:0] rdPtr;
  logic [flitSwitchPkg::CountWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      creditReturn <= 1'b0;
    end
    else
    begin
      if (inValid)
        wrPtr <= wrPtr + flitSwitchPkg::PtrWidth'(1);
      if (pop)
        rdPtr <= rdPtr + flitSwitchPkg::PtrWidth'(1);
      case ({inValid, pop})
        2'b10: count <= count + flitSwitchPkg::CountWidth'(1);
        2'b01: count <= count - flitSwitchPkg::CountWidth'(1);
        default: count <= count;
      endcase
      // Each drained slot goes back to the sender as one credit
      creditReturn <= pop;
    end
  end

  assign req = (count != '0);
  assign frontFlit = mem[rdPtr];

  // Only a head flit carries a length, body and tail words are payload
  assign frontLength = (frontFlit.kind == flitSwitchPkg::Head) ?
                       frontFlit.data.header.length : '0;

  // Upstream credits must keep the sender off a full buffer
  assert property (@(posedge clk) disable iff (rst)
    inValid |-> count != flitSwitchPkg::CountWidth'(flitSwitchPkg::BufDepth));

  // The arbiter pops only a port that requests
  assert property (@(posedge clk) disable iff (rst)
    pop |-> req);

endmodule

//--- logic/flitSwitchPkg.sv
package flitSwitchPkg;

  localparam int NumPorts = 5;
  localparam int BufDepth = 4;
  localparam int OutCredits = 4;
  localparam int LengthWidth = 12;

  localparam int SelWidth = $clog2(NumPorts);
  localparam int PtrWidth = $clog2(BufDepth);
  localparam int CountWidth = $clog2(BufDepth + 1);
  localparam int CreditWidth = $clog2(OutCredits + 1);

  // Index order is also the rotation order of the arbiter
  localparam logic [SelWidth-1:0] PortL = SelWidth'(0);
  localparam logic [SelWidth-1:0] PortN = SelWidth'(1);
  localparam logic [SelWidth-1:0] PortE = SelWidth'(2);
  localparam logic [SelWidth-1:0] PortW = SelWidth'(3);
  localparam logic [SelWidth-1:0] PortS = SelWidth'(4);

  typedef enum logic [1:0]
  {
    Head = 2'b01,
    Body = 2'b10,
    Tail = 2'b11
  } flitKind_t;

  // Length counts every flit of the packet including the head
  typedef struct packed
  {
    logic [3:0] dest;
    logic [LengthWidth-1:0] length;
  } headerView_t;

  typedef union packed
  {
    headerView_t header;
    logic [15:0] payload;
  } flitData_t;

  typedef struct packed
  {
    flitKind_t kind;
    flitData_t data;
  } flit_t;

  typedef logic [NumPorts-1:0] portMask_t;

  // Bit 0 is idle, bit i+1 means port i holds the link
  typedef logic [NumPorts:0] arbState_t;
  localparam arbState_t StateIdle = arbState_t'(1);

endpackage
